// ==== verilog/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    localparam int DATA_WIDTH   = 68;
    localparam int PARITY_WIDTH = 8;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;

    // Syndrome produced by a flip of each data bit, data bit 0 first.
    localparam logic [PARITY_WIDTH-1:0] CHECK_COLUMNS [0:DATA_WIDTH-1] = '{
        8'h83, 8'h85, 8'h86, 8'h07, 8'h89, 8'h8a, 8'h0b, 8'h8c,
        8'h0d, 8'h0e, 8'h8f, 8'h91, 8'h92, 8'h13, 8'h94, 8'h15,
        8'h16, 8'h97, 8'h98, 8'h19, 8'h1a, 8'h9b, 8'h1c, 8'h9d,
        8'h9e, 8'h1f, 8'ha1, 8'ha2, 8'h23, 8'ha4, 8'h25, 8'h26,
        8'ha7, 8'ha8, 8'h29, 8'h2a, 8'hab, 8'h2c, 8'had, 8'hae,
        8'h2f, 8'hb0, 8'h31, 8'h32, 8'hb3, 8'h34, 8'hb5, 8'hb6,
        8'h37, 8'h38, 8'hb9, 8'hba, 8'h3b, 8'hbc, 8'h3d, 8'h3e,
        8'hbf, 8'hc1, 8'hc2, 8'h43, 8'hc4, 8'h45, 8'h46, 8'hc7,
        8'hc8, 8'h49, 8'h4a, 8'hcb
    };

    // Check bits sit above the data, so codeword bit 68 is check bit 0.
    typedef struct packed {
        logic [PARITY_WIDTH-1:0] parity;
        logic [DATA_WIDTH-1:0]   data;
    } codeword_t;

    typedef struct packed {
        logic                    valid;
        logic                    bypass;
        codeword_t               codeword;
        logic [PARITY_WIDTH-1:0] syndrome;
    } synd_stage_t;

    function automatic logic [PARITY_WIDTH-1:0] ecc_parity(input logic [DATA_WIDTH-1:0] data);
        logic [PARITY_WIDTH-1:0] parity;
        parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            parity ^= CHECK_COLUMNS[i] & {PARITY_WIDTH{data[i]}}; // Each bit adds its column.
        end
        return parity;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    import ecc_pkg::*;

    localparam int ADDR_WIDTH = 4;
    localparam int DEPTH      = 1 << ADDR_WIDTH;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [CODE_WIDTH-1:0] flip; // Codeword bits to invert before storage.
    } wr_req_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  bypass;
    } rd_req_t;

    // Travels with the read codeword out of the array.
    typedef struct packed {
        logic valid;
        logic bypass;
    } rd_tag_t;

endpackage

`default_nettype wire

// ==== verilog/ecc_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_encoder
    import ecc_pkg::*;
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  wr_req_t               wr,
    output logic                  wr_en_q,
    output logic [ADDR_WIDTH-1:0] wr_addr_q,
    output codeword_t             wr_code_q
);

    codeword_t clean_code;
    codeword_t flipped_code;

    assign clean_code.parity = ecc_parity(wr.data);
    assign clean_code.data   = wr.data;

    // Injected flips may land on data or check bits alike.
    assign flipped_code = codeword_t'(clean_code ^ wr.flip);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= wr.en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            wr_addr_q <= wr.addr;
            wr_code_q <= flipped_code;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ecc_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_array
    import ecc_pkg::*;
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  codeword_t             wr_code,
    input  rd_req_t               rd,
    output codeword_t             rd_code,
    output rd_tag_t               rd_tag
);

    codeword_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_code;
        end
    end

    // A read on the same edge as a write sees the old word.
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_code       <= mem[rd.addr];
            rd_tag.bypass <= rd.bypass;
        end
        if (rst) begin
            rd_tag.valid <= 1'b0;
        end else begin
            rd_tag.valid <= rd.en;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ecc_syndrome.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_syndrome
    import ecc_pkg::*;
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  codeword_t   rd_code,
    input  rd_tag_t     rd_tag,
    output synd_stage_t stage
);

    logic [PARITY_WIDTH-1:0] recomputed;
    logic [PARITY_WIDTH-1:0] syndrome;

    assign recomputed = ecc_parity(rd_code.data);
    assign syndrome   = recomputed ^ rd_code.parity; // Zero when the word is clean.

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= rd_tag.valid;
        end

        // Payload only moves with a live read.
        if (rd_tag.valid) begin
            stage.bypass   <= rd_tag.bypass;
            stage.codeword <= rd_code;
            stage.syndrome <= syndrome;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ecc_corrector.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_corrector
    import ecc_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  synd_stage_t           stage,
    output logic                  rd_valid,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    logic [DATA_WIDTH-1:0] mask;
    logic                  sbit_hit;
    logic                  dbit_hit;
    logic [DATA_WIDTH-1:0] fixed_data;

    always_comb begin
        mask     = '0;
        sbit_hit = 1'b0;
        dbit_hit = 1'b0;
        if (stage.syndrome != '0) begin
            if ($onehot(stage.syndrome)) begin
                sbit_hit = 1'b1; // Only a check bit flipped so the data is intact.
            end else begin
                dbit_hit = 1'b1;
                for (int i = 0; i < DATA_WIDTH; i++) begin
                    if (stage.syndrome == CHECK_COLUMNS[i]) begin
                        mask[i]  = 1'b1;
                        sbit_hit = 1'b1;
                        dbit_hit = 1'b0;
                    end
                end
            end
        end
    end

    // Uncorrectable words are passed on as stored.
    assign fixed_data = stage.codeword.data ^ mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            rd_valid <= stage.valid;
            sbit_err <= stage.valid & ~stage.bypass & sbit_hit;
            dbit_err <= stage.valid & ~stage.bypass & dbit_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (stage.valid) begin
            rd_data <= stage.bypass ? stage.codeword.data : fixed_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ecc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top
    import ecc_pkg::*;
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  wr_req_t               wr,
    input  rd_req_t               rd,
    output logic                  rd_valid,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    logic                  wr_en_q;
    logic [ADDR_WIDTH-1:0] wr_addr_q;
    codeword_t             wr_code_q;
    codeword_t             rd_code;
    rd_tag_t               rd_tag;
    synd_stage_t           stage;

    ecc_encoder u_encoder (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .wr_en_q   (wr_en_q),
        .wr_addr_q (wr_addr_q),
        .wr_code_q (wr_code_q)
    );

    ecc_array u_array (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en_q),
        .wr_addr (wr_addr_q),
        .wr_code (wr_code_q),
        .rd      (rd),
        .rd_code (rd_code),
        .rd_tag  (rd_tag)
    );

    ecc_syndrome u_syndrome (
        .clk     (clk),
        .rst     (rst),
        .rd_code (rd_code),
        .rd_tag  (rd_tag),
        .stage   (stage)
    );

    // Three edges from read request to rd_valid.
    ecc_corrector u_corrector (
        .clk      (clk),
        .rst      (rst),
        .stage    (stage),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err)
    );

endmodule

`default_nettype wire

// ==== tests/ecc_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_tb
    import ecc_pkg::*;
    import mem_pkg::*;
();

    localparam int NUM_ROWS    = 30;
    localparam int POOL_SIZE   = 12;
    localparam int LATENCY     = 3;
    localparam int DRAIN_LIMIT = 40;
    localparam logic [6:0] NO_FLIP = 7'h7f;

    typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_RD} op_t;

    typedef struct packed {
        op_t                   op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [3:0]            seed_idx;
        logic [6:0]            flip_a;
        logic [6:0]            flip_b;
        logic                  bypass;
    } access_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  sbit;
        logic                  dbit;
        logic [31:0]           issued;
    } expect_t;

    logic                  clk;
    logic                  rst;
    wr_req_t               wr;
    rd_req_t               rd;
    logic                  rd_valid;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  sbit_err;
    logic                  dbit_err;

    access_t               rows [NUM_ROWS];
    logic [DATA_WIDTH-1:0] pool [POOL_SIZE];
    logic [DATA_WIDTH-1:0] shadow_data [DEPTH];
    logic [CODE_WIDTH-1:0] shadow_flip [DEPTH];
    expect_t               expected_q [$];
    int                    seed;
    int                    errors;
    int                    checks;
    logic [31:0]           cycle;
    logic                  monitor_on;

    ecc_mem_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .rd       (rd),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1; // Free-running count used to measure read latency.
    end

    function automatic access_t make_row(input op_t op, input int addr, input int seed_idx,
                                         input int flip_a, input int flip_b, input int bypass);
        access_t r;
        r.op       = op;
        r.addr     = ADDR_WIDTH'(addr);
        r.seed_idx = 4'(seed_idx);
        r.flip_a   = (flip_a < 0) ? NO_FLIP : 7'(flip_a);
        r.flip_b   = (flip_b < 0) ? NO_FLIP : 7'(flip_b);
        r.bypass   = (bypass != 0);
        return r;
    endfunction

    // Codeword bit 68 + j is check bit j and its column has only bit j set.
    function automatic logic [PARITY_WIDTH-1:0] column_of(input int pos);
        if (pos < DATA_WIDTH) begin
            return CHECK_COLUMNS[pos];
        end
        return PARITY_WIDTH'(1) << (pos - DATA_WIDTH);
    endfunction

    function automatic logic [CODE_WIDTH-1:0] flip_mask(input logic [6:0] a, input logic [6:0] b);
        logic [CODE_WIDTH-1:0] mask;
        mask = '0;
        if (a != NO_FLIP) mask[a] = 1'b1;
        if (b != NO_FLIP) mask[b] = 1'b1;
        return mask;
    endfunction

    // The code is linear, so the syndrome of a stored word is the XOR of the flipped columns.
    function automatic expect_t predict(input logic [DATA_WIDTH-1:0] data,
                                        input logic [CODE_WIDTH-1:0] flip, input logic bypass);
        expect_t               want;
        logic [PARITY_WIDTH-1:0] syndrome;
        logic [DATA_WIDTH-1:0] stored;
        logic [DATA_WIDTH-1:0] one_hot;
        syndrome = '0;
        for (int p = 0; p < CODE_WIDTH; p++) begin
            if (flip[p]) syndrome ^= column_of(p);
        end
        stored      = data ^ flip[DATA_WIDTH-1:0];
        want        = '0;
        want.data   = stored;
        if (!bypass && syndrome != '0) begin
            if ($countones(syndrome) == 1) begin
                want.sbit = 1'b1;
            end else begin
                want.dbit = 1'b1;
                for (int i = 0; i < DATA_WIDTH; i++) begin
                    if (syndrome == CHECK_COLUMNS[i]) begin
                        one_hot    = '0;
                        one_hot[i] = 1'b1;
                        want.data  = stored ^ one_hot;
                        want.sbit  = 1'b1;
                        want.dbit  = 1'b0;
                    end
                end
            end
        end
        return want;
    endfunction

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %h actual %h at cycle %0d",
                     name, expected, actual, cycle);
            errors++;
        end
    endtask

    task automatic fill_pool();
        logic [95:0] word;
        for (int i = 0; i < POOL_SIZE; i++) begin
            word    = {$random(seed), $random(seed), $random(seed)};
            pool[i] = word[DATA_WIDTH-1:0];
        end
    endtask

    task automatic load_rows();
        rows[0]  = make_row(OP_WR, 0, 0, -1, -1, 0);
        rows[1]  = make_row(OP_WR, 1, 1, 0, -1, 0);
        rows[2]  = make_row(OP_WR, 2, 2, 67, -1, 0);
        rows[3]  = make_row(OP_WR, 3, 3, 33, -1, 0);
        rows[4]  = make_row(OP_WR, 4, 4, 68, -1, 0); // Check bit 0.
        rows[5]  = make_row(OP_WR, 5, 5, 75, -1, 0);
        rows[6]  = make_row(OP_WR, 6, 6, 5, 40, 0);
        rows[7]  = make_row(OP_WR, 7, 7, 12, 70, 0);
        rows[8]  = make_row(OP_WR, 8, 8, 20, -1, 0);
        rows[9]  = make_row(OP_WR, 9, 9, 3, 50, 0);
        rows[10] = make_row(OP_WR, 10, 10, 71, -1, 0);
        rows[11] = make_row(OP_WR, 11, 11, 60, 61, 0);
        rows[12] = make_row(OP_IDLE, 0, 0, -1, -1, 0);
        rows[13] = make_row(OP_RD, 0, 0, -1, -1, 0);
        rows[14] = make_row(OP_IDLE, 0, 0, -1, -1, 0);
        rows[15] = make_row(OP_IDLE, 0, 0, -1, -1, 0);
        rows[16] = make_row(OP_IDLE, 0, 0, -1, -1, 0);
        rows[17] = make_row(OP_RD, 1, 0, -1, -1, 0);
        rows[18] = make_row(OP_RD, 2, 0, -1, -1, 0);
        rows[19] = make_row(OP_RD, 3, 0, -1, -1, 0);
        rows[20] = make_row(OP_RD, 4, 0, -1, -1, 0);
        rows[21] = make_row(OP_RD, 5, 0, -1, -1, 0);
        rows[22] = make_row(OP_RD, 6, 0, -1, -1, 0);
        rows[23] = make_row(OP_RD, 7, 0, -1, -1, 0);
        rows[24] = make_row(OP_RD, 8, 0, -1, -1, 1);
        rows[25] = make_row(OP_RD, 9, 0, -1, -1, 1);
        rows[26] = make_row(OP_RD, 10, 0, -1, -1, 0);
        rows[27] = make_row(OP_RD, 11, 0, -1, -1, 0);
        rows[28] = make_row(OP_RD, 6, 0, -1, -1, 1);
        rows[29] = make_row(OP_RD, 0, 0, -1, -1, 1);
    endtask

    task automatic apply_row(input access_t r);
        expect_t want;
        wr = '0;
        rd = '0;
        case (r.op)
            OP_WR: begin
                wr.en   = 1'b1;
                wr.addr = r.addr;
                wr.data = pool[r.seed_idx];
                wr.flip = flip_mask(r.flip_a, r.flip_b);
                shadow_data[r.addr] = pool[r.seed_idx];
                shadow_flip[r.addr] = flip_mask(r.flip_a, r.flip_b);
            end
            OP_RD: begin
                rd.en     = 1'b1;
                rd.addr   = r.addr;
                rd.bypass = r.bypass;
                want      = predict(shadow_data[r.addr], shadow_flip[r.addr], r.bypass);
                want.issued = cycle;
                expected_q.push_back(want);
            end
            default: ;
        endcase
    endtask

    // Outputs are sampled on the falling edge away from the driving edge.
    always @(negedge clk) begin
        expect_t want;
        if (monitor_on) begin
            if (rd_valid) begin
                assert (expected_q.size() != 0) else begin
                    $display("rd_valid pulsed with no read outstanding at cycle %0d", cycle);
                    errors++;
                end
                if (expected_q.size() != 0) begin
                    want = expected_q.pop_front();
                    check_value("rd_data", want.data, rd_data);
                    check_value("sbit_err", DATA_WIDTH'(want.sbit), DATA_WIDTH'(sbit_err));
                    check_value("dbit_err", DATA_WIDTH'(want.dbit), DATA_WIDTH'(dbit_err));
                    check_value("rd_valid latency", DATA_WIDTH'(LATENCY),
                                DATA_WIDTH'(cycle - want.issued));
                end
            end else begin
                check_value("sbit_err", '0, DATA_WIDTH'(sbit_err));
                check_value("dbit_err", '0, DATA_WIDTH'(dbit_err));
            end
        end
    end

    initial begin
        int drain;
        seed       = 70548;
        errors     = 0;
        checks     = 0;
        cycle      = '0;
        monitor_on = 1'b0;
        rst        = 1'b1;
        wr         = '0;
        rd         = '0;
        fill_pool();
        load_rows();
        repeat (2) @(posedge clk);
        #1;
        rst        = 1'b0;
        monitor_on = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
            @(posedge clk);
            #1;
        end
        wr = '0;
        rd = '0;

        drain = 0;
        while (expected_q.size() != 0 && drain < DRAIN_LIMIT) begin
            @(posedge clk);
            drain++;
        end
        assert (expected_q.size() == 0) else begin
            $display("Timed out with %0d reads still waiting for rd_valid", expected_q.size());
            errors++;
        end
        repeat (4) @(posedge clk); // Catch any stray rd_valid pulse.

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ecc_mem_top.f ====
verilog/ecc_pkg.sv
verilog/mem_pkg.sv
verilog/ecc_encoder.sv
verilog/ecc_array.sv
verilog/ecc_syndrome.sv
verilog/ecc_corrector.sv
verilog/ecc_mem_top.sv
tests/ecc_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module ecc_mem_tb \
    -f ecc_mem_top.f -o ecc_mem_sim &&
sim_out=$(./obj_dir/ecc_mem_sim) &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -qx "Test OK" &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }
